// File: hw/apb_params.svh
// Shared sizes for RTL and testbench; APB_CMD_DEPTH must be a power of two, APB_NUM_REGS <= 2**(APB_ADDR_WIDTH-2)
`ifndef APB_PARAMS_SVH
`define APB_PARAMS_SVH

// Bus widths
`define APB_ADDR_WIDTH 8            // Byte address, word registers
`define APB_DATA_WIDTH 32           // Data and register width

// Command queue
`define APB_CMD_DEPTH 4             // Entries, power of two

// Register bank timing
`define APB_SLV_WAIT 2              // Wait cycles before PREADY

// Register map
`define APB_NUM_REGS 16             // Last word is read-only ID
`define APB_ID_VALUE 32'h0A9B_0001  // Identity register contents

`endif

// File: hw/apb_bus_pkg.sv
// APB protocol types only; phase encoding is two bits and IDLE must stay at zero
package apb_bus_pkg;

    // Master transfer phase
    typedef enum logic [1:0] {
        IDLE   = 2'b00, // No transfer, PSEL low
        SETUP  = 2'b01, // PSEL high, PENABLE low
        ACCESS = 2'b10  // PSEL and PENABLE high
    } apb_phase_e;

endpackage

// File: hw/apb_cmd_pkg.sv
// Client command types only; opcode bit value maps straight onto PWRITE
package apb_cmd_pkg;

    // Command opcode
    typedef enum logic {
        OP_READ  = 1'b0, // PWRITE low
        OP_WRITE = 1'b1  // PWRITE high
    } apb_opcode_e;

endpackage

// File: hw/apb_cmd_fifo.sv
// Command queue without fall-through; a push is visible one cycle later, depth must be a power of two
`timescale 1ns/1ps
`include "apb_params.svh"

module apb_cmd_fifo (
    input  logic                        i_clk_apb,   // APB clock
    input  logic                        i_rstn_apb,  // Async reset, active low
    input  logic                        i_in_valid,  // Client command valid
    output logic                        o_in_ready,  // Space available
    input  logic [`APB_ADDR_WIDTH-1:0]  i_in_addr,   // Client address
    input  apb_cmd_pkg::apb_opcode_e    i_in_opcode, // Client opcode
    input  logic [`APB_DATA_WIDTH-1:0]  i_in_wdata,  // Client write data
    output logic                        o_out_valid, // Entry available
    input  logic                        i_out_ready, // Master takes entry
    output logic [`APB_ADDR_WIDTH-1:0]  o_out_addr,  // Head address
    output apb_cmd_pkg::apb_opcode_e    o_out_opcode, // Head opcode
    output logic [`APB_DATA_WIDTH-1:0]  o_out_wdata  // Head write data
);

    import apb_cmd_pkg::*;

    localparam int PTR_W = $clog2(`APB_CMD_DEPTH); // Index bits without wrap

    // Storage, no reset needed
    logic [`APB_ADDR_WIDTH-1:0] addr_mem  [0:`APB_CMD_DEPTH-1];
    apb_opcode_e                op_mem    [0:`APB_CMD_DEPTH-1];
    logic [`APB_DATA_WIDTH-1:0] wdata_mem [0:`APB_CMD_DEPTH-1];

    logic [PTR_W:0] wr_ptr_q;   // MSB is the wrap bit
    logic [PTR_W:0] rd_ptr_q;   // MSB is the wrap bit
    logic [PTR_W:0] count;      // Occupancy
    logic           push;
    logic           pop;
    logic           full;
    logic           empty;

    assign count = wr_ptr_q - rd_ptr_q;
    assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]); // Same slot, other lap
    assign empty = (wr_ptr_q == rd_ptr_q);

    assign o_in_ready  = !full;            // Only back-pressure to client
    assign o_out_valid = !empty;
    assign push        = i_in_valid && o_in_ready;
    assign pop         = o_out_valid && i_out_ready;

    // Head of queue, registered storage so no fall-through
    assign o_out_addr   = addr_mem[rd_ptr_q[PTR_W-1:0]];
    assign o_out_opcode = op_mem[rd_ptr_q[PTR_W-1:0]];
    assign o_out_wdata  = wdata_mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge i_clk_apb) begin
        if (push) begin
            addr_mem[wr_ptr_q[PTR_W-1:0]]  <= i_in_addr;
            op_mem[wr_ptr_q[PTR_W-1:0]]    <= i_in_opcode;
            wdata_mem[wr_ptr_q[PTR_W-1:0]] <= i_in_wdata;
        end
    end

    // Pointers move independently, push and pop may coincide
    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // Occupancy bounded by depth
    a_no_overflow: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        count <= (PTR_W+1)'(`APB_CMD_DEPTH));

    // Stalled head must not change under the master
    a_head_stable: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        (o_out_valid && !i_out_ready) |=>
            (o_out_valid && $stable(o_out_addr) && $stable(o_out_opcode) &&
             $stable(o_out_wdata)));

endmodule

// File: hw/apb_master.sv
// Single-slave APB master; no PSTRB or PPROT, response has no back-pressure and pulses once
`timescale 1ns/1ps
`include "apb_params.svh"

module apb_master (
    input  logic                        i_clk_apb,    // APB clock
    input  logic                        i_rstn_apb,   // Async reset, active low
    input  logic                        i_valid,      // Command from queue
    output logic                        o_ready,      // Command accepted
    input  logic [`APB_ADDR_WIDTH-1:0]  i_addr,       // Command address
    input  apb_cmd_pkg::apb_opcode_e    i_opcode,     // Command opcode
    input  logic [`APB_DATA_WIDTH-1:0]  i_wr_data,    // Command write data
    output logic                        o_psel,       // Peripheral select
    output logic                        o_penable,    // Access phase
    output logic                        o_pwrite,     // Direction
    output logic [`APB_ADDR_WIDTH-1:0]  o_paddr,      // Transfer address
    output logic [`APB_DATA_WIDTH-1:0]  o_pwdata,     // Transfer write data
    input  logic [`APB_DATA_WIDTH-1:0]  i_prdata,     // Slave read data
    input  logic                        i_pready,     // Slave done
    input  logic                        i_pslverr,    // Slave error
    output logic                        o_rsp_valid,  // One-cycle response pulse
    output apb_cmd_pkg::apb_opcode_e    o_rsp_opcode, // Opcode of finished command
    output logic [`APB_DATA_WIDTH-1:0]  o_rsp_rdata,  // Read data, zero otherwise
    output logic                        o_rsp_err     // Slave error passed through
);

    import apb_bus_pkg::*;
    import apb_cmd_pkg::*;

    apb_phase_e                 state_q;
    apb_phase_e                 state_d;
    apb_opcode_e                op_q;       // Held command
    logic [`APB_ADDR_WIDTH-1:0] addr_q;
    logic [`APB_DATA_WIDTH-1:0] wdata_q;
    logic                       accept;
    logic                       done;       // Completing ACCESS cycle

    assign done   = (state_q == ACCESS) && i_pready;
    assign accept = o_ready && i_valid;

    // Ready in IDLE, or as the current transfer finishes
    assign o_ready = (state_q == IDLE) || done;

    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Command payload, captured on handshake only
    always_ff @(posedge i_clk_apb) begin
        if (accept) begin
            op_q    <= i_opcode;
            addr_q  <= i_addr;
            wdata_q <= i_wr_data;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_valid) state_d = SETUP;   // Taken this cycle
            end
            SETUP: begin
                state_d = ACCESS;               // SETUP is one cycle
            end
            ACCESS: begin
                if (i_pready) begin
                    state_d = i_valid ? SETUP : IDLE; // Back to back if more queued
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Bus drive, quiet while idle
    always_comb begin
        o_psel    = (state_q == SETUP) || (state_q == ACCESS);
        o_penable = (state_q == ACCESS);
        o_pwrite  = o_psel && (op_q == OP_WRITE);
        o_paddr   = o_psel ? addr_q : '0;
        o_pwdata  = o_pwrite ? wdata_q : '0;   // Zero on reads
    end

    // Response built in the completing cycle
    always_comb begin
        o_rsp_valid  = done;
        o_rsp_opcode = op_q;
        o_rsp_err    = done && i_pslverr;
        o_rsp_rdata  = '0;
        if (done && (op_q == OP_READ) && !i_pslverr) begin
            o_rsp_rdata = i_prdata;
        end
    end

    // ACCESS entered only from a SETUP cycle
    a_penable_psel: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        $rose(o_penable) |-> $past(o_psel && !o_penable));

    // Address and direction held through wait states
    a_access_stable: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        (o_psel && o_penable && !i_pready) |=>
            (o_psel && o_penable && $stable(o_paddr) && $stable(o_pwrite)));

endmodule

// File: hw/apb_reg_slave.sv
// Word-addressed register bank; fixed wait states, last word is a read-only ID, no byte strobes
`timescale 1ns/1ps
`include "apb_params.svh"

module apb_reg_slave (
    input  logic                        i_clk_apb,  // APB clock
    input  logic                        i_rstn_apb, // Async reset, active low
    input  logic                        i_psel,     // Selected
    input  logic                        i_penable,  // Access phase
    input  logic                        i_pwrite,   // Direction
    input  logic [`APB_ADDR_WIDTH-1:0]  i_paddr,    // Byte address
    input  logic [`APB_DATA_WIDTH-1:0]  i_pwdata,   // Write data
    output logic [`APB_DATA_WIDTH-1:0]  o_prdata,   // Read data
    output logic                        o_pready,   // Transfer done
    output logic                        o_pslverr   // Illegal access
);

    localparam int IDX_W  = `APB_ADDR_WIDTH - 2;         // Word index bits
    localparam int REG_W  = $clog2(`APB_NUM_REGS);       // Bits to select a register
    localparam int WAIT_W = $clog2(`APB_SLV_WAIT + 2);   // At least one bit
    localparam logic [IDX_W-1:0] ID_IDX = IDX_W'(`APB_NUM_REGS - 1);

    // Writable registers, the ID word is not stored
    logic [`APB_DATA_WIDTH-1:0] regs_q [0:`APB_NUM_REGS-2];
    logic [WAIT_W-1:0]          wait_cnt_q;
    logic [IDX_W-1:0]           word_idx;
    logic [REG_W-1:0]           reg_idx;
    logic                       access;
    logic                       misaligned;
    logic                       out_of_range;
    logic                       id_hit;
    logic                       err;
    logic                       wr_en;

    assign access       = i_psel && i_penable;
    assign word_idx     = i_paddr[`APB_ADDR_WIDTH-1:2];  // Offset is index times 4
    assign reg_idx      = word_idx[REG_W-1:0];
    assign misaligned   = |i_paddr[1:0];
    assign out_of_range = (word_idx >= IDX_W'(`APB_NUM_REGS));
    assign id_hit       = (word_idx == ID_IDX);

    // Any one of these makes the access illegal
    assign err = misaligned || out_of_range || (id_hit && i_pwrite);

    // Ready in the (WAIT+1)th ACCESS cycle
    assign o_pready  = access && (wait_cnt_q == WAIT_W'(`APB_SLV_WAIT));
    assign o_pslverr = o_pready && err;
    assign wr_en     = o_pready && i_pwrite && !err;   // Errored writes change nothing

    // Counts ACCESS cycles, cleared between transfers
    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            wait_cnt_q <= '0;
        end else if (access && !o_pready) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end else begin
            wait_cnt_q <= '0;
        end
    end

    // Register file, cleared on reset
    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            for (int i = 0; i < `APB_NUM_REGS - 1; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[reg_idx] <= i_pwdata;
        end
    end

    // Read path, zero for writes and errored reads
    always_comb begin
        o_prdata = '0;
        if (access && !i_pwrite && !err) begin
            if (id_hit) begin
                o_prdata = `APB_ID_VALUE;   // Fixed identity word
            end else begin
                o_prdata = regs_q[reg_idx];
            end
        end
    end

    // PREADY only after the full wait inside ACCESS
    a_pready_in_access: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        o_pready |-> $past(access, `APB_SLV_WAIT));

endmodule

// File: hw/apb_subsys_top.sv
// Queue, APB master and register bank on one segment; client must sample every response pulse
`timescale 1ns/1ps
`include "apb_params.svh"

module apb_subsys_top (
    input  logic                        i_clk_apb,    // APB clock
    input  logic                        i_rstn_apb,   // Async reset, active low
    input  logic                        i_cmd_valid,  // Client command valid
    output logic                        o_cmd_ready,  // Queue has space
    input  logic [`APB_ADDR_WIDTH-1:0]  i_cmd_addr,   // Byte address
    input  apb_cmd_pkg::apb_opcode_e    i_cmd_opcode, // Read or write
    input  logic [`APB_DATA_WIDTH-1:0]  i_cmd_wdata,  // Write data
    output logic                        o_rsp_valid,  // One pulse per command
    output apb_cmd_pkg::apb_opcode_e    o_rsp_opcode, // Opcode echoed
    output logic [`APB_DATA_WIDTH-1:0]  o_rsp_rdata,  // Read data or zero
    output logic                        o_rsp_err     // Slave error
);

    import apb_cmd_pkg::*;

    // Queue to master
    logic                       cmd_valid;
    logic                       cmd_ready;
    logic [`APB_ADDR_WIDTH-1:0] cmd_addr;
    apb_opcode_e                cmd_opcode;
    logic [`APB_DATA_WIDTH-1:0] cmd_wdata;

    // APB segment
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;

    apb_cmd_fifo apb_cmd_fifo_inst (
        .i_clk_apb(i_clk_apb), .i_rstn_apb(i_rstn_apb),
        .i_in_valid(i_cmd_valid), .o_in_ready(o_cmd_ready), .i_in_addr(i_cmd_addr),
        .i_in_opcode(i_cmd_opcode), .i_in_wdata(i_cmd_wdata),
        .o_out_valid(cmd_valid), .i_out_ready(cmd_ready), .o_out_addr(cmd_addr),
        .o_out_opcode(cmd_opcode), .o_out_wdata(cmd_wdata)
    );

    apb_master apb_master_inst (
        .i_clk_apb(i_clk_apb), .i_rstn_apb(i_rstn_apb),
        .i_valid(cmd_valid), .o_ready(cmd_ready), .i_addr(cmd_addr),
        .i_opcode(cmd_opcode), .i_wr_data(cmd_wdata),
        .o_psel(psel), .o_penable(penable), .o_pwrite(pwrite), .o_paddr(paddr),
        .o_pwdata(pwdata), .i_prdata(prdata), .i_pready(pready), .i_pslverr(pslverr),
        .o_rsp_valid(o_rsp_valid), .o_rsp_opcode(o_rsp_opcode),
        .o_rsp_rdata(o_rsp_rdata), .o_rsp_err(o_rsp_err)
    );

    apb_reg_slave apb_reg_slave_inst (
        .i_clk_apb(i_clk_apb), .i_rstn_apb(i_rstn_apb),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
        .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
    );

endmodule

// File: verification/apb_subsys_tb.sv
// Drives only the client port; assumes an idle system after reset, latency is checked on single commands
`timescale 1ns/1ps
`include "apb_params.svh"

module apb_subsys_tb;

    import apb_bus_pkg::*;
    import apb_cmd_pkg::*;

    localparam int AW         = `APB_ADDR_WIDTH;
    localparam int DW         = `APB_DATA_WIDTH;
    localparam int NREG       = `APB_NUM_REGS;
    localparam int MAX_CMDS   = 128;                        // Expected-response slots
    localparam int TOTAL_CMDS = 73;                         // Commands over all tests
    localparam int LAT        = 1 + 1 + 1 + (`APB_SLV_WAIT + 1); // Accept, queue, SETUP, ACCESS
    localparam int WD_CYCLES  = TOTAL_CMDS * (2 + `APB_SLV_WAIT) + 200; // Plus drain margin

    logic              i_clk_apb;
    logic              i_rstn_apb;
    logic              i_cmd_valid;
    logic              o_cmd_ready;
    logic [AW-1:0]     i_cmd_addr;
    apb_opcode_e       i_cmd_opcode;
    logic [DW-1:0]     i_cmd_wdata;
    logic              o_rsp_valid;
    apb_opcode_e       o_rsp_opcode;
    logic [DW-1:0]     o_rsp_rdata;
    logic              o_rsp_err;

    // Register model, ID word not stored
    logic [DW-1:0]     model_regs [0:NREG-2] = '{default: '0};
    logic [DW-1:0]     snap_regs  [0:NREG-2];
    // Expected responses in command order
    apb_opcode_e       exp_op      [0:MAX_CMDS-1];
    logic [DW-1:0]     exp_rdata   [0:MAX_CMDS-1];
    logic              exp_err     [0:MAX_CMDS-1];
    logic              exp_lat_chk [0:MAX_CMDS-1];
    int                exp_acc_cyc [0:MAX_CMDS-1];
    int                exp_cnt     = 0;   // Commands accepted
    int                rsp_idx     = 0;   // Responses seen
    int                cycle_cnt   = 0;
    int                full_cnt    = 0;   // Cycles with valid held against a full queue
    int                rsp_errs    = 0;   // Concurrent check failures
    int                proc_errs   = 0;   // Immediate check failures
    int                tests_run   = 0;
    int                tests_pass  = 0;
    logic              rsp_seen    = 1'b0;
    logic              lat_check_on;
    logic [31:0]       rng_state;

    apb_subsys_top apb_subsys_top_inst (
        .i_clk_apb    (i_clk_apb),
        .i_rstn_apb   (i_rstn_apb),
        .i_cmd_valid  (i_cmd_valid),
        .o_cmd_ready  (o_cmd_ready),
        .i_cmd_addr   (i_cmd_addr),
        .i_cmd_opcode (i_cmd_opcode),
        .i_cmd_wdata  (i_cmd_wdata),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_opcode (o_rsp_opcode),
        .o_rsp_rdata  (o_rsp_rdata),
        .o_rsp_err    (o_rsp_err)
    );

    initial begin
        i_clk_apb = 1'b0;
        forever #4 i_clk_apb = ~i_clk_apb;   // 8 ns period
    end

    // xorshift32 step on the shared state
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int total_errs();
        return rsp_errs + proc_errs;
    endfunction

    // Applies the register-bank rules at acceptance
    task automatic record_cmd(input logic [AW-1:0] addr, input apb_opcode_e op,
                              input logic [DW-1:0] wdata);
        int            idx;
        logic          bad;
        logic [DW-1:0] rdata;
        idx   = int'(addr[AW-1:2]);
        bad   = (addr[1:0] != 2'b00) || (idx >= NREG) || ((idx == NREG - 1) && (op == OP_WRITE));
        rdata = '0;
        if (!bad && (op == OP_WRITE)) begin
            model_regs[idx] = wdata;
        end else if (!bad && (idx == NREG - 1)) begin
            rdata = `APB_ID_VALUE;                 // Identity word
        end else if (!bad) begin
            rdata = model_regs[idx];
        end
        exp_op[exp_cnt]      = op;
        exp_rdata[exp_cnt]   = rdata;             // Zero for writes and errors
        exp_err[exp_cnt]     = bad;
        exp_lat_chk[exp_cnt] = lat_check_on;
        exp_acc_cyc[exp_cnt] = cycle_cnt;
        exp_cnt <= exp_cnt + 1;
    endtask

    // Mid-cycle monitor, everything stable here
    always @(negedge i_clk_apb) begin
        if (i_rstn_apb && i_cmd_valid && o_cmd_ready) begin
            record_cmd(i_cmd_addr, i_cmd_opcode, i_cmd_wdata);   // Taken at next edge
        end
        if (i_rstn_apb && i_cmd_valid && !o_cmd_ready) begin
            full_cnt <= full_cnt + 1;
        end
        rsp_seen <= o_rsp_valid;
    end

    always @(posedge i_clk_apb) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rsp_seen) rsp_idx <= rsp_idx + 1;   // Advance past checked response
    end

    a_rsp_expected: assert property (@(negedge i_clk_apb) disable iff (!i_rstn_apb)
        o_rsp_valid |-> (rsp_idx < exp_cnt))
        else begin
            rsp_errs = rsp_errs + 1;
            $display("Response arrived with no command outstanding");
        end

    a_rsp_opcode: assert property (@(negedge i_clk_apb) disable iff (!i_rstn_apb)
        (o_rsp_valid && (rsp_idx < exp_cnt)) |-> (o_rsp_opcode == exp_op[rsp_idx]))
        else begin
            rsp_errs = rsp_errs + 1;
            $display("Error: o_rsp_opcode = %h, expected %h", o_rsp_opcode, exp_op[rsp_idx]);
        end

    a_rsp_rdata: assert property (@(negedge i_clk_apb) disable iff (!i_rstn_apb)
        (o_rsp_valid && (rsp_idx < exp_cnt)) |-> (o_rsp_rdata == exp_rdata[rsp_idx]))
        else begin
            rsp_errs = rsp_errs + 1;
            $display("Error: o_rsp_rdata = %h, expected %h", o_rsp_rdata, exp_rdata[rsp_idx]);
        end

    a_rsp_err: assert property (@(negedge i_clk_apb) disable iff (!i_rstn_apb)
        (o_rsp_valid && (rsp_idx < exp_cnt)) |-> (o_rsp_err == exp_err[rsp_idx]))
        else begin
            rsp_errs = rsp_errs + 1;
            $display("Error: o_rsp_err = %h, expected %h", o_rsp_err, exp_err[rsp_idx]);
        end

    // Both end cycles counted
    a_rsp_latency: assert property (@(negedge i_clk_apb) disable iff (!i_rstn_apb)
        (o_rsp_valid && (rsp_idx < exp_cnt) && exp_lat_chk[rsp_idx]) |->
            ((cycle_cnt - exp_acc_cyc[rsp_idx] + 1) == LAT))
        else begin
            rsp_errs = rsp_errs + 1;
            $display("Error: o_rsp_valid latency = %h cycles, expected %h",
                     cycle_cnt - exp_acc_cyc[rsp_idx] + 1, LAT);
        end

    // SETUP always followed by ACCESS
    a_phase_legal: assert property (@(negedge i_clk_apb) disable iff (!i_rstn_apb)
        (apb_subsys_top_inst.apb_master_inst.state_q == SETUP) |=>
            (apb_subsys_top_inst.apb_master_inst.state_q == ACCESS))
        else begin
            rsp_errs = rsp_errs + 1;
            $display("APB master left SETUP for a phase other than ACCESS");
        end

    // Valid held until the queue takes it
    task automatic push_cmd(input logic [AW-1:0] addr, input apb_opcode_e op,
                            input logic [DW-1:0] wdata);
        @(posedge i_clk_apb);
        i_cmd_valid  <= 1'b1;
        i_cmd_addr   <= addr;
        i_cmd_opcode <= op;
        i_cmd_wdata  <= wdata;
        @(negedge i_clk_apb);
        while (!o_cmd_ready) @(negedge i_clk_apb);
    endtask

    // Drop valid, wait for every outstanding response
    task automatic finish_cmds();
        @(posedge i_clk_apb);
        i_cmd_valid <= 1'b0;
        @(negedge i_clk_apb);
        while (rsp_idx != exp_cnt) @(negedge i_clk_apb);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (total_errs() == errs_before) begin
            tests_pass = tests_pass + 1;
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d checks failed", tests_run, name, total_errs() - errs_before);
        end
    endtask

    initial begin
        int            errs;
        int            full_before;
        logic [31:0]   r;
        logic [AW-1:0] addr;
        apb_opcode_e   op;
        i_rstn_apb   = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd_addr   = '0;
        i_cmd_opcode = OP_READ;
        i_cmd_wdata  = '0;
        lat_check_on = 1'b0;
        rng_state    = 32'he3a;

        errs = total_errs();
        repeat (2) @(posedge i_clk_apb);
        i_rstn_apb <= 1'b1;
        @(negedge i_clk_apb);
        a_reset_idle: assert (!o_rsp_valid && o_cmd_ready) else begin
            proc_errs = proc_errs + 1;
            $display("Error: o_rsp_valid = %h, o_cmd_ready = %h, expected 0 and 1",
                     o_rsp_valid, o_cmd_ready);
        end
        lat_check_on = 1'b1;
        push_cmd(AW'(0), OP_READ, '0);
        finish_cmds();
        lat_check_on = 1'b0;
        end_test("reset state and latency", errs);

        errs = total_errs();
        for (int i = 0; i < NREG - 1; i++) push_cmd(AW'(i * 4), OP_WRITE, next_rand());
        for (int i = 0; i < NREG - 1; i++) push_cmd(AW'(i * 4), OP_READ, '0);
        finish_cmds();
        end_test("write then read back", errs);

        errs = total_errs();
        push_cmd(AW'((NREG - 1) * 4), OP_READ, '0);
        push_cmd(AW'((NREG - 1) * 4), OP_WRITE, next_rand());   // Read-only, errors
        push_cmd(AW'((NREG - 1) * 4), OP_READ, '0);
        finish_cmds();
        end_test("identity register", errs);

        errs = total_errs();
        snap_regs = model_regs;
        push_cmd(AW'('h05), OP_WRITE, next_rand());   // Misaligned
        push_cmd(AW'(NREG * 4), OP_WRITE, next_rand());   // Past last register
        push_cmd(AW'('h06), OP_READ, '0);
        push_cmd(AW'('hFC), OP_READ, '0);
        for (int i = 0; i < NREG - 1; i++) push_cmd(AW'(i * 4), OP_READ, '0);
        finish_cmds();
        for (int i = 0; i < NREG - 1; i++) begin
            a_model_kept: assert (model_regs[i] == snap_regs[i]) else begin
                proc_errs = proc_errs + 1;
                $display("Error: model register %0d = %h, expected %h",
                         i, model_regs[i], snap_regs[i]);
            end
        end
        end_test("illegal addresses", errs);

        errs        = total_errs();
        full_before = full_cnt;
        for (int i = 0; i < 20; i++) begin
            r    = next_rand();
            addr = (r[2:0] == 3'b000) ? r[15:8] : {2'b00, r[11:8], 2'b00};   // Mostly legal
            op   = r[31] ? OP_WRITE : OP_READ;
            push_cmd(addr, op, next_rand());
        end
        finish_cmds();
        a_saw_full: assert (full_cnt > full_before) else begin
            proc_errs = proc_errs + 1;
            $display("The queue never held o_cmd_ready low during the burst");
        end
        end_test("back-pressure and ordering", errs);

        $display("Tests run %0d, passed %0d, failed checks %0d", tests_run, tests_pass,
                 total_errs());
        if ((total_errs() == 0) && (tests_pass == tests_run)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Bounded by the command count at full throughput
    initial begin
        repeat (WD_CYCLES) @(posedge i_clk_apb);
        $display("Timeout after %0d cycles, responses stopped arriving", WD_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/apb_bus_pkg.sv
hw/apb_cmd_pkg.sv
hw/apb_cmd_fifo.sv
hw/apb_master.sv
hw/apb_reg_slave.sv
hw/apb_subsys_top.sv
verification/apb_subsys_tb.sv

// File: Makefile
# Verilator build and run of the APB subsystem testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = apb_subsys_tb
FILELIST  = tb.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
